// ==== design/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// rob index width, entry count follows from it
`define ROB_WIDTH 6
`define ROB_DEPTH 64

// architectural register index width
`define ARF_WIDTH 5

// data path width, also pc width
`define XLEN 32

`endif

// ==== design/rob_pkg.sv ====
`include "rob_cfg.svh"

package rob_pkg;

    //////////////////////////////////////////////////////////////////////
    // basic vector types
    //////////////////////////////////////////////////////////////////////

    // rob entry index, doubles as physical destination name
    typedef logic [`ROB_WIDTH-1:0] rob_tag_t;
    typedef logic [`ARF_WIDTH-1:0] areg_t;
    typedef logic [`XLEN-1:0]      xdata_t;
    // instruction class
    typedef logic [1:0]            inst_type_t;

    //////////////////////////////////////////////////////////////////////
    // table entries
    //////////////////////////////////////////////////////////////////////

    // flags raised by execution
    typedef struct packed {
        logic exception;
        logic bpu_fail;
    } rob_ctrl_entry_t;

    // static info, written at dispatch
    typedef struct packed {
        inst_type_t inst_type;
        areg_t      areg;
        xdata_t     pc;
        logic       w_reg;
        logic       w_mem;
    } rob_inst_entry_t;

    // result, written by the cdb
    typedef struct packed {
        xdata_t          data;
        rob_ctrl_entry_t ctrl;
    } rob_data_entry_t;

    //////////////////////////////////////////////////////////////////////
    // external packets
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        inst_type_t      inst_type;
        areg_t           areg;
        rob_tag_t [1:0]  src_tag;
        xdata_t          pc;
        logic            issue;
        logic            w_reg;
        logic            w_mem;
    } dispatch_rob_pkg_t;

    typedef struct packed {
        rob_tag_t        w_tag;
        xdata_t          w_data;
        logic            w_valid;
        rob_ctrl_entry_t ctrl;
    } cdb_rob_pkg_t;

    typedef struct packed {
        xdata_t          w_data;
        areg_t           w_areg;
        xdata_t          pc;
        logic            w_reg;
        logic            w_mem;
        rob_ctrl_entry_t ctrl;
        logic            c_ready;
    } commit_rob_pkg_t;

    // source operand readout
    typedef struct packed {
        xdata_t data;
        logic   ready;
    } rob_operand_t;

endpackage

// ==== design/rob_regfile.sv ====
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_regfile
    import rob_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int R_PORTS    = 2,
    parameter int W_PORTS    = 2
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    // read side
    input  rob_tag_t [R_PORTS-1:0]               raddr_i,
    output logic     [R_PORTS-1:0][DATA_WIDTH-1:0] rdata_o,
    // write side
    input  rob_tag_t [W_PORTS-1:0]               waddr_i,
    input  logic     [W_PORTS-1:0]               we_i,
    input  logic     [W_PORTS-1:0][DATA_WIDTH-1:0] wdata_i
);

    // one word per rob entry
    logic [`ROB_DEPTH-1:0][DATA_WIDTH-1:0] mem_q;

    //////////////////////////////////////////////////////////////////////
    // write
    //////////////////////////////////////////////////////////////////////

    // later port in the loop wins on equal address
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_q <= '0;
        end else begin
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) begin
                    mem_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read
    //////////////////////////////////////////////////////////////////////

    // no bypass, a write shows up after the edge
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem_q[raddr_i[r]];
        end
    end

    // every pair of write ports must hit distinct entries
    for (genvar a = 0; a < W_PORTS; a++) begin : g_wchk_a
        for (genvar b = a + 1; b < W_PORTS; b++) begin : g_wchk_b
            a_no_wr_collision: assert property (
                @(posedge clk) disable iff (!arst_n_i)
                !(we_i[a] && we_i[b] && (waddr_i[a] == waddr_i[b]))
            ) else $error("rob_regfile: ports %0d and %0d write entry %0d", a, b, waddr_i[a]);
        end
    end

endmodule

// ==== design/rob_complete_table.sv ====
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_complete_table
    import rob_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           flush_i,
    // dispatch allocation
    input  rob_tag_t [1:0] alloc_tag_i,
    input  logic     [1:0] alloc_i,
    // completion from the cdb
    input  rob_tag_t [1:0] cdb_tag_i,
    input  logic     [1:0] cdb_valid_i,
    // retirement
    input  rob_tag_t [1:0] retire_tag_i,
    input  logic     [1:0] retire_i,
    // operand lookup
    input  rob_tag_t [3:0] src_tag_i,
    output logic     [3:0] src_ready_o,
    // oldest two entries
    input  rob_tag_t [1:0] tail_tag_i,
    output logic     [1:0] tail_valid_o,
    output logic     [1:0] tail_complete_o
);

    // one bit each per entry
    logic [`ROB_DEPTH-1:0] valid_q;
    logic [`ROB_DEPTH-1:0] complete_q;

    //////////////////////////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q    <= '0;
            complete_q <= '0;
        end else if (flush_i) begin
            // stale complete bits get cleared on the next allocation
            valid_q <= '0;
        end else begin
            // retire and alloc never touch the same entry
            for (int i = 0; i < 2; i++) begin
                if (retire_i[i]) begin
                    valid_q[retire_tag_i[i]] <= 1'b0;
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (alloc_i[i]) begin
                    valid_q[alloc_tag_i[i]]    <= 1'b1;
                    complete_q[alloc_tag_i[i]] <= 1'b0;
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (cdb_valid_i[i]) begin
                    complete_q[cdb_tag_i[i]] <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lookups
    //////////////////////////////////////////////////////////////////////

    // a source is ready only while its producer still sits in the rob
    always_comb begin
        for (int s = 0; s < 4; s++) begin
            src_ready_o[s] = valid_q[src_tag_i[s]] & complete_q[src_tag_i[s]];
        end
        for (int t = 0; t < 2; t++) begin
            tail_valid_o[t]    = valid_q[tail_tag_i[t]];
            tail_complete_o[t] = complete_q[tail_tag_i[t]];
        end
    end

    // completion must land on a live entry, and the two cdb ports never collide
    for (genvar i = 0; i < 2; i++) begin : g_cdb_chk
        a_cdb_live: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            (cdb_valid_i[i] && !flush_i) |-> valid_q[cdb_tag_i[i]]
        ) else $error("rob_complete_table: cdb %0d writes free entry %0d", i, cdb_tag_i[i]);
    end

    a_cdb_distinct: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (&cdb_valid_i) |-> (cdb_tag_i[0] != cdb_tag_i[1])
    ) else $error("rob_complete_table: both cdb ports write entry %0d", cdb_tag_i[0]);

endmodule

// ==== design/rob_commit_ctrl.sv ====
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_commit_ctrl
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  flush_i,
    // dispatch side
    input  logic            [1:0] issue_i,
    output rob_tag_t        [1:0] alloc_tag_o,
    output logic            [1:0] alloc_o,
    // commit side
    output rob_tag_t        [1:0] tail_tag_o,
    input  logic            [1:0] tail_valid_i,
    input  logic            [1:0] tail_complete_i,
    input  rob_ctrl_entry_t [1:0] tail_ctrl_i,
    output logic            [1:0] commit_en_o,
    output logic                  rob_ready_o
);

    // head is the next free entry, tail the oldest live one
    rob_tag_t            head_q;
    rob_tag_t            tail_q;
    // needs one extra bit to hold a full rob
    logic [`ROB_WIDTH:0] count_q;
    logic [1:0]          alloc_cnt;
    logic [1:0]          commit_cnt;
    logic                chain_ok;

    //////////////////////////////////////////////////////////////////////
    // allocation
    //////////////////////////////////////////////////////////////////////

    // room for a full pair
    assign rob_ready_o = (count_q <= (`ROB_DEPTH - 2));

    // issues packed onto consecutive tags from head
    assign alloc_tag_o[0] = head_q;
    assign alloc_tag_o[1] = issue_i[0] ? head_q + 1'b1 : head_q;
    // dispatch in a flush cycle is dropped
    assign alloc_o        = issue_i & {2{~flush_i}};
    assign alloc_cnt      = {1'b0, alloc_o[0]} + {1'b0, alloc_o[1]};

    //////////////////////////////////////////////////////////////////////
    // commit selection
    //////////////////////////////////////////////////////////////////////

    assign tail_tag_o[0] = tail_q;
    assign tail_tag_o[1] = tail_q + 1'b1;

    // strictly in order; a redirecting entry stops the younger slot
    always_comb begin
        chain_ok = ~flush_i;
        for (int i = 0; i < 2; i++) begin
            commit_en_o[i] = chain_ok & tail_valid_i[i] & tail_complete_i[i];
            chain_ok       = commit_en_o[i]
                           & ~tail_ctrl_i[i].exception
                           & ~tail_ctrl_i[i].bpu_fail;
        end
    end

    assign commit_cnt = {1'b0, commit_en_o[0]} + {1'b0, commit_en_o[1]};

    //////////////////////////////////////////////////////////////////////
    // pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // whole rob emptied
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + rob_tag_t'(alloc_cnt);
            tail_q  <= tail_q + rob_tag_t'(commit_cnt);
            count_q <= count_q + alloc_cnt - commit_cnt;
        end
    end

    // dispatch may only issue while there is room for a pair
    a_issue_when_ready: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (|issue_i) |-> rob_ready_o
    ) else $error("rob_commit_ctrl: issue with rob_ready_o low, count %0d", count_q);

endmodule

// ==== design/rob.sv ====
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob
    import rob_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    flush_i,
    input  dispatch_rob_pkg_t [1:0] dispatch_i,
    input  cdb_rob_pkg_t      [1:0] cdb_i,
    output rob_tag_t          [1:0] alloc_tag_o,
    output rob_operand_t      [3:0] operand_o,
    output commit_rob_pkg_t   [1:0] commit_o,
    output logic                    rob_ready_o
);

    // controller
    logic            [1:0] issue;
    logic            [1:0] alloc;
    rob_tag_t        [1:0] tail_tag;
    logic            [1:0] tail_valid;
    logic            [1:0] tail_complete;
    rob_ctrl_entry_t [1:0] tail_ctrl;
    logic            [1:0] commit_en;

    // instruction table
    rob_inst_entry_t [1:0] inst_wr;
    rob_inst_entry_t [1:0] inst_rd;

    // data table, ports 0..3 sources, 4..5 tail
    rob_tag_t        [1:0] cdb_tag;
    logic            [1:0] cdb_we;
    rob_data_entry_t [1:0] data_wr;
    rob_tag_t        [5:0] data_raddr;
    rob_data_entry_t [5:0] data_rd;
    logic            [3:0] src_ready;

    //////////////////////////////////////////////////////////////////////
    // unpack dispatch and cdb
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            issue[i]             = dispatch_i[i].issue;
            inst_wr[i].inst_type = dispatch_i[i].inst_type;
            inst_wr[i].areg      = dispatch_i[i].areg;
            inst_wr[i].pc        = dispatch_i[i].pc;
            inst_wr[i].w_reg     = dispatch_i[i].w_reg;
            inst_wr[i].w_mem     = dispatch_i[i].w_mem;
            // results arriving during a flush are dropped
            cdb_tag[i]           = cdb_i[i].w_tag;
            cdb_we[i]            = cdb_i[i].w_valid & ~flush_i;
            data_wr[i].data      = cdb_i[i].w_data;
            data_wr[i].ctrl      = cdb_i[i].ctrl;
            // src0 and src1 of slot i
            data_raddr[2*i]      = dispatch_i[i].src_tag[0];
            data_raddr[2*i+1]    = dispatch_i[i].src_tag[1];
            data_raddr[4+i]      = tail_tag[i];
            tail_ctrl[i]         = data_rd[4+i].ctrl;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control and tables
    //////////////////////////////////////////////////////////////////////

    rob_commit_ctrl i_commit_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .issue_i         (issue),
        .alloc_tag_o     (alloc_tag_o),
        .alloc_o         (alloc),
        .tail_tag_o      (tail_tag),
        .tail_valid_i    (tail_valid),
        .tail_complete_i (tail_complete),
        .tail_ctrl_i     (tail_ctrl),
        .commit_en_o     (commit_en),
        .rob_ready_o     (rob_ready_o)
    );

    rob_complete_table i_complete_table (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .alloc_tag_i     (alloc_tag_o),
        .alloc_i         (alloc),
        .cdb_tag_i       (cdb_tag),
        .cdb_valid_i     (cdb_we),
        .retire_tag_i    (tail_tag),
        .retire_i        (commit_en),
        .src_tag_i       (data_raddr[3:0]),
        .src_ready_o     (src_ready),
        .tail_tag_i      (tail_tag),
        .tail_valid_o    (tail_valid),
        .tail_complete_o (tail_complete)
    );

    // static info, written at dispatch, read at the tail
    rob_regfile #(
        .DATA_WIDTH ($bits(rob_inst_entry_t)),
        .R_PORTS    (2),
        .W_PORTS    (2)
    ) i_inst_table (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_i  (tail_tag),
        .rdata_o  (inst_rd),
        .waddr_i  (alloc_tag_o),
        .we_i     (alloc),
        .wdata_i  (inst_wr)
    );

    // results, written by the cdb
    rob_regfile #(
        .DATA_WIDTH ($bits(rob_data_entry_t)),
        .R_PORTS    (6),
        .W_PORTS    (2)
    ) i_data_table (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_i  (data_raddr),
        .rdata_o  (data_rd),
        .waddr_i  (cdb_tag),
        .we_i     (cdb_we),
        .wdata_i  (data_wr)
    );

    //////////////////////////////////////////////////////////////////////
    // pack commit and operand outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit_o[i].w_data  = data_rd[4+i].data;
            commit_o[i].w_areg  = inst_rd[i].areg;
            commit_o[i].pc      = inst_rd[i].pc;
            commit_o[i].w_reg   = inst_rd[i].w_reg;
            commit_o[i].w_mem   = inst_rd[i].w_mem;
            commit_o[i].ctrl    = data_rd[4+i].ctrl;
            commit_o[i].c_ready = commit_en[i];
        end
        // data passes through, ready qualifies it
        for (int s = 0; s < 4; s++) begin
            operand_o[s].data  = data_rd[s].data;
            operand_o[s].ready = src_ready[s];
        end
    end

endmodule

// ==== dv/rob_tb.sv ====
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_tb
    import rob_pkg::*;
();

    typedef commit_rob_pkg_t [1:0] commit_pair_t;

    // cycle limit for every wait loop
    localparam int STEP_MAX = 300;

    logic                    clk;
    logic                    arst_n_i;
    logic                    flush_i;
    dispatch_rob_pkg_t [1:0] dispatch_i;
    cdb_rob_pkg_t      [1:0] cdb_i;
    rob_tag_t          [1:0] alloc_tag_o;
    rob_operand_t      [3:0] operand_o;
    commit_rob_pkg_t   [1:0] commit_o;
    logic                    rob_ready_o;

    // reference model keeps age order in m_q and contents per tag
    rob_tag_t        m_q[$];
    logic            m_valid [`ROB_DEPTH];
    logic            m_done  [`ROB_DEPTH];
    rob_inst_entry_t m_inst  [`ROB_DEPTH];
    rob_data_entry_t m_res   [`ROB_DEPTH];
    rob_tag_t        m_head;

    // tags dispatched but not yet sent on the cdb
    rob_tag_t    pend_q[$];
    int unsigned lcg_state;
    int          err_cnt;
    int          test_pass;
    int          test_fail;

    rob i_rob (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .dispatch_i  (dispatch_i),
        .cdb_i       (cdb_i),
        .alloc_tag_o (alloc_tag_o),
        .operand_o   (operand_o),
        .commit_o    (commit_o),
        .rob_ready_o (rob_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // random numbers
    //////////////////////////////////////////////////////////////////////

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // upper half only since the low lcg bits cycle quickly
    function automatic int unsigned rand_below(int unsigned n);
        return (lcg_next() >> 16) % n;
    endfunction

    function automatic xdata_t rand_word();
        int unsigned hi;
        int unsigned lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    task automatic reset_model();
        m_q.delete();
        m_head = '0;
        for (int t = 0; t < `ROB_DEPTH; t++) begin
            m_valid[t] = 1'b0;
            m_done[t]  = 1'b0;
            m_inst[t]  = '0;
            m_res[t]   = '0;
        end
    endtask

    // younger slot commits only behind a clean older commit
    function automatic commit_pair_t ref_commit();
        commit_pair_t exp;
        rob_tag_t     t;
        logic         chain;
        exp   = '0;
        chain = ~flush_i;
        for (int i = 0; i < 2; i++) begin
            if (i < m_q.size()) begin
                t = m_q[i];
                exp[i].w_data  = m_res[t].data;
                exp[i].w_areg  = m_inst[t].areg;
                exp[i].pc      = m_inst[t].pc;
                exp[i].w_reg   = m_inst[t].w_reg;
                exp[i].w_mem   = m_inst[t].w_mem;
                exp[i].ctrl    = m_res[t].ctrl;
                exp[i].c_ready = chain & m_done[t];
                chain = exp[i].c_ready & ~m_res[t].ctrl.exception & ~m_res[t].ctrl.bpu_fail;
            end
        end
        return exp;
    endfunction

    function automatic rob_operand_t ref_operand(rob_tag_t t);
        rob_operand_t exp;
        exp.data  = m_res[t].data;
        exp.ready = m_valid[t] & m_done[t];
        return exp;
    endfunction

    // slot 1 takes head when slot 0 is idle
    function automatic rob_tag_t ref_alloc_tag(int slot);
        if (slot == 1 && dispatch_i[0].issue) begin
            return m_head + 1'b1;
        end
        return m_head;
    endfunction

    function automatic logic ref_ready();
        return m_q.size() <= (`ROB_DEPTH - 2);
    endfunction

    // state change at the rising edge
    task automatic model_edge(commit_pair_t exp);
        rob_tag_t t;
        if (flush_i) begin
            m_q.delete();
            m_head = '0;
            for (int k = 0; k < `ROB_DEPTH; k++) begin
                m_valid[k] = 1'b0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (exp[i].c_ready) begin
                    t = m_q.pop_front();
                    m_valid[t] = 1'b0;
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (cdb_i[i].w_valid) begin
                    m_done[cdb_i[i].w_tag] = 1'b1;
                    m_res[cdb_i[i].w_tag]  = {cdb_i[i].w_data, cdb_i[i].ctrl};
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (dispatch_i[i].issue) begin
                    t = m_head;
                    m_inst[t].inst_type = dispatch_i[i].inst_type;
                    m_inst[t].areg      = dispatch_i[i].areg;
                    m_inst[t].pc        = dispatch_i[i].pc;
                    m_inst[t].w_reg     = dispatch_i[i].w_reg;
                    m_inst[t].w_mem     = dispatch_i[i].w_mem;
                    m_valid[t] = 1'b1;
                    m_done[t]  = 1'b0;
                    m_q.push_back(t);
                    m_head = m_head + 1'b1;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks and monitor
    //////////////////////////////////////////////////////////////////////

    // payload only matters while c_ready is expected
    task automatic check_commit(string name, commit_rob_pkg_t exp, commit_rob_pkg_t act);
        if (exp.c_ready && act !== exp) begin
            err_cnt++;
            $display("FAIL %s: expected %h, got %h", name, exp, act);
        end else if (!exp.c_ready && act.c_ready !== 1'b0) begin
            err_cnt++;
            $display("FAIL %s.c_ready: expected 0, got %h", name, act.c_ready);
        end
    endtask

    task automatic check_operand(string name, rob_operand_t exp, rob_operand_t act);
        if (exp.ready && act !== exp) begin
            err_cnt++;
            $display("FAIL %s: expected %h, got %h", name, exp, act);
        end else if (!exp.ready && act.ready !== 1'b0) begin
            err_cnt++;
            $display("FAIL %s.ready: expected 0, got %h", name, act.ready);
        end
    endtask

    task automatic check_tag(string name, rob_tag_t exp, rob_tag_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("FAIL %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_ready(string name, logic exp, logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("FAIL %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // sample 1 ns before each edge and then step the model
    initial begin
        commit_pair_t exp_c;
        forever begin
            @(posedge clk);
            #19;
            if (arst_n_i) begin
                exp_c = ref_commit();
                for (int i = 0; i < 2; i++) begin
                    check_commit($sformatf("commit_o[%0d]", i), exp_c[i], commit_o[i]);
                    check_tag($sformatf("alloc_tag_o[%0d]", i), ref_alloc_tag(i),
                              alloc_tag_o[i]);
                end
                for (int s = 0; s < 4; s++) begin
                    check_operand($sformatf("operand_o[%0d]", s),
                                  ref_operand(dispatch_i[s / 2].src_tag[s % 2]), operand_o[s]);
                end
                check_ready("rob_ready_o", ref_ready(), rob_ready_o);
                model_edge(exp_c);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_on_timeout(string what);
        $display("timeout: %s", what);
        $display("Regression failed");
        $finish;
    endtask

    // drop the strobes and pick fresh random source tags
    task automatic next_cycle();
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        for (int i = 0; i < 2; i++) begin
            dispatch_i[i].issue = 1'b0;
            cdb_i[i].w_valid    = 1'b0;
            cdb_i[i].ctrl       = '0;
            for (int j = 0; j < 2; j++) begin
                dispatch_i[i].src_tag[j] = rob_tag_t'(rand_below(`ROB_DEPTH));
            end
        end
    endtask

    // slot 0 first when both issue
    task automatic dispatch_slot(int i);
        dispatch_i[i].inst_type = inst_type_t'(rand_below(4));
        dispatch_i[i].areg      = areg_t'(rand_below(32));
        dispatch_i[i].pc        = rand_word();
        dispatch_i[i].w_reg     = 1'(rand_below(2));
        dispatch_i[i].w_mem     = 1'(rand_below(2));
        pend_q.push_back(ref_alloc_tag(i));
        dispatch_i[i].issue     = 1'b1;
    endtask

    task automatic drive_cdb(int port, rob_tag_t t, rob_ctrl_entry_t c);
        cdb_i[port].w_tag   = t;
        cdb_i[port].w_data  = rand_word();
        cdb_i[port].ctrl    = c;
        cdb_i[port].w_valid = 1'b1;
    endtask

    task automatic complete_pending(int port, int idx, rob_ctrl_entry_t c);
        rob_tag_t t;
        t = pend_q[idx];
        pend_q.delete(idx);
        drive_cdb(port, t, c);
    endtask

    // zero to two completions in random order
    task automatic complete_random();
        for (int p = 0; p < 2; p++) begin
            if (pend_q.size() != 0 && rand_below(3) != 0) begin
                complete_pending(p, rand_below(pend_q.size()), '0);
            end
        end
    endtask

    task automatic set_sources(rob_tag_t s0, rob_tag_t s1, rob_tag_t s2, rob_tag_t s3);
        dispatch_i[0].src_tag[0] = s0;
        dispatch_i[0].src_tag[1] = s1;
        dispatch_i[1].src_tag[0] = s2;
        dispatch_i[1].src_tag[1] = s3;
    endtask

    // a dispatch driven this cycle is still only in pend_q
    task automatic drain(string what);
        int n;
        n = 0;
        while ((m_q.size() != 0 || pend_q.size() != 0) && n < STEP_MAX) begin
            next_cycle();
            complete_random();
            n++;
        end
        if (m_q.size() != 0 || pend_q.size() != 0) begin
            abort_on_timeout(what);
        end
    endtask

    task automatic wait_ready(logic level, string what);
        int n;
        n = 0;
        while (rob_ready_o !== level && n < STEP_MAX) begin
            next_cycle();
            n++;
        end
        if (rob_ready_o !== level) begin
            abort_on_timeout(what);
        end
    endtask

    // lets the last cycle's check land before the verdict
    task automatic finish_test(string name, int errs_before);
        next_cycle();
        if (err_cnt == errs_before) begin
            test_pass++;
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: %0d mismatches", name, err_cnt - errs_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        int       errs;
        rob_tag_t a;
        rob_tag_t b;
        lcg_state  = 31;
        err_cnt    = 0;
        test_pass  = 0;
        test_fail  = 0;
        arst_n_i   = 1'b0;
        flush_i    = 1'b0;
        dispatch_i = '0;
        cdb_i      = '0;
        reset_model();
        repeat (2) @(posedge clk);
        #2;
        arst_n_i = 1'b1;

        // first pair after reset lands on tags 0 and 1
        errs = err_cnt;
        next_cycle();
        check_tag("alloc_tag_o[0] after reset", '0, alloc_tag_o[0]);
        check_ready("rob_ready_o after reset", 1'b1, rob_ready_o);
        dispatch_slot(0);
        dispatch_slot(1);
        drain("ROB did not drain after reset test");
        finish_test("reset", errs);

        // random issue widths and completion order
        errs = err_cnt;
        for (int k = 0; k < 80; k++) begin
            next_cycle();
            complete_random();
            if (m_q.size() <= `ROB_DEPTH - 2) begin
                case (rand_below(3))
                    1: dispatch_slot(rand_below(2));
                    2: begin
                        dispatch_slot(0);
                        dispatch_slot(1);
                    end
                    default: ;
                endcase
            end
        end
        drain("ROB did not drain after random traffic");
        finish_test("random_order", errs);

        // a lone younger completion holds until both retire together
        errs = err_cnt;
        next_cycle();
        dispatch_slot(0);
        dispatch_slot(1);
        next_cycle();
        complete_pending(0, 1, '0);
        next_cycle();
        next_cycle();
        complete_pending(1, 0, '0);
        drain("ROB did not drain after pair commit");
        finish_test("pair_commit", errs);

        // only the completed younger tag reads as ready
        errs = err_cnt;
        next_cycle();
        dispatch_slot(0);
        dispatch_slot(1);
        a = pend_q[0];
        b = pend_q[1];
        next_cycle();
        complete_pending(0, 1, '0);
        next_cycle();
        set_sources(a, b, b, a);
        next_cycle();
        dispatch_slot(0);
        dispatch_slot(1);
        set_sources(b, pend_q[1], pend_q[2], a);
        drain("ROB did not drain after operand reads");
        finish_test("operands", errs);

        // fill all 64 entries and free space with two commits
        errs = err_cnt;
        for (int k = 0; k < 32; k++) begin
            next_cycle();
            dispatch_slot(0);
            dispatch_slot(1);
        end
        next_cycle();
        wait_ready(1'b0, "rob_ready_o stayed high with a full ROB");
        complete_pending(0, 0, '0);
        complete_pending(1, 0, '0);
        wait_ready(1'b1, "rob_ready_o stayed low after commits");
        drain("ROB did not drain after fill");
        finish_test("full", errs);

        // a redirecting oldest entry retires alone before a flush empties the rob
        errs = err_cnt;
        next_cycle();
        dispatch_slot(0);
        dispatch_slot(1);
        next_cycle();
        complete_pending(0, 0, '{exception: 1'b0, bpu_fail: 1'b1});
        complete_pending(1, 0, '0);
        drain("ROB did not drain after bpu_fail commit");
        next_cycle();
        dispatch_slot(0);
        dispatch_slot(1);
        a = pend_q[1];
        next_cycle();
        complete_pending(0, 0, '{exception: 1'b1, bpu_fail: 1'b0});
        complete_pending(1, 0, '0);
        next_cycle();
        next_cycle();
        // dispatch and cdb here must be dropped
        flush_i = 1'b1;
        dispatch_slot(0);
        dispatch_slot(1);
        drive_cdb(0, a, '0);
        pend_q.delete();
        repeat (3) next_cycle();
        check_tag("alloc_tag_o[0] after flush", '0, alloc_tag_o[0]);
        dispatch_slot(0);
        dispatch_slot(1);
        drain("ROB did not drain after flush");
        finish_test("redirect_flush", errs);

        $display("tests passed: %0d, tests failed: %0d", test_pass, test_fail);
        if (test_fail == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/rob_pkg.sv
design/rob_regfile.sv
design/rob_complete_table.sv
design/rob_commit_ctrl.sv
design/rob.sv
dv/rob_tb.sv
